/* verilog/fetch_pkg.sv */
//////////////////////////////
// shared types and default sizes for the instruction prefetch subsystem
// modules refer to these by scoped name, fetch_pkg::name
//////////////////////////////
`default_nettype none

package fetch_pkg;

  // default number of fifo words, must be 3 or more
  localparam int FIFO_DEPTH_DEFAULT = 3;
  // default limit on granted requests still waiting for rvalid
  localparam int MAX_OUTSTANDING_DEFAULT = 2;

  // one returned bus word on its way into the fifo
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] rdata;
    logic        err;
  } fetch_rsp_t;

  // one aligned instruction, only the low half counts when compressed
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] instr;
    logic        err;
  } fetch_instr_t;

  // request side of the instruction bus
  typedef struct packed {
    logic        req;
    logic [31:0] addr;
  } bus_req_t;

  // grant and in-order response side of the instruction bus
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
    logic        err;
  } bus_rsp_t;

  // requester FSM
  typedef enum logic [1:0] {
    REQ_IDLE,
    REQ_FETCH,
    REQ_FLUSH
  } req_state_e;

endpackage

`default_nettype wire

/* verilog/fetch_fifo.sv */
//////////////////////////////
// fetch FIFO with instruction realignment
// stores returned words and hands out one 16 or 32 bit instruction per transfer
// responses are never refused, the requester keeps room free
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fetch_fifo #(
  parameter int FIFO_DEPTH = fetch_pkg::FIFO_DEPTH_DEFAULT
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,
  input  fetch_pkg::fetch_rsp_t           rsp_i,
  input  logic                            rsp_valid_i,
  output logic [$clog2(FIFO_DEPTH+1)-1:0] occupancy_o,
  output fetch_pkg::fetch_instr_t         instr_o,
  output logic                            instr_valid_o,
  input  logic                            instr_ready_i
);

  localparam int OCC_W = $clog2(FIFO_DEPTH + 1);

  // entry 0 is the head
  logic [FIFO_DEPTH-1:0][31:0] addr_q, addr_int, addr_n;
  logic [FIFO_DEPTH-1:0][31:0] rdata_q, rdata_int, rdata_n;
  logic [FIFO_DEPTH-1:0]       err_q, err_int, err_n;
  logic [FIFO_DEPTH-1:0]       valid_q, valid_int, valid_n;

  logic [31:0] head_addr;
  logic [31:0] head_rdata;
  logic        head_err;
  logic        head_valid;
  logic [15:0] next_half;
  logic        next_err;
  logic        pair_valid;
  logic        al_compressed;
  logic        un_compressed;
  logic        out_valid;
  logic        transfer;
  logic [29:0] word_next;

  //////////////////////////////
  // head and realignment
  //////////////////////////////

  // empty fifo: incoming word bypasses the head
  assign head_rdata = valid_q[0] ? rdata_q[0] : rsp_i.rdata;
  assign head_err   = valid_q[0] ? err_q[0] : rsp_i.err;
  assign head_addr  = valid_q[0] ? addr_q[0] : rsp_i.addr;
  assign head_valid = valid_q[0] | rsp_valid_i;

  // second word for an unaligned 32 bit instruction
  assign next_half  = valid_q[1] ? rdata_q[1][15:0] : rsp_i.rdata[15:0];
  assign next_err   = valid_q[1] ? err_q[1] : rsp_i.err;
  assign pair_valid = valid_q[1] | (valid_q[0] & rsp_valid_i);

  // low two bits not both one means 16 bit
  assign al_compressed = head_rdata[1:0] != 2'b11;
  assign un_compressed = head_rdata[17:16] != 2'b11;

  always_comb begin
    instr_o.addr = head_addr;
    if (head_addr[1]) begin
      // upper half of the head joined with lower half of the next word
      instr_o.instr = {next_half, head_rdata[31:16]};
      instr_o.err   = head_err | (~un_compressed & next_err);
      out_valid     = un_compressed ? head_valid : pair_valid;
    end else begin
      instr_o.instr = head_rdata;
      instr_o.err   = head_err;
      out_valid     = head_valid;
    end
  end

  // nothing goes out while a branch is flushing the fifo
  assign instr_valid_o = out_valid & ~clear_i;
  assign transfer      = instr_valid_o & instr_ready_i;

  //////////////////////////////
  // fill and advance
  //////////////////////////////

  // incoming word goes to the first free entry
  always_comb begin
    logic placed;
    placed    = 1'b0;
    addr_int  = addr_q;
    rdata_int = rdata_q;
    err_int   = err_q;
    valid_int = valid_q;
    if (rsp_valid_i) begin
      for (int i = 0; i < FIFO_DEPTH; i++) begin
        if (!valid_q[i] && !placed) begin
          addr_int[i]  = rsp_i.addr;
          rdata_int[i] = rsp_i.rdata;
          err_int[i]   = rsp_i.err;
          valid_int[i] = 1'b1;
          placed       = 1'b1;
        end
      end
    end
  end

  assign word_next = addr_int[0][31:2] + 30'h1;

  always_comb begin
    addr_n  = addr_int;
    rdata_n = rdata_int;
    err_n   = err_int;
    valid_n = valid_int;
    if (transfer) begin
      if (!head_addr[1] && al_compressed) begin
        // stay in the same word, move to its upper half
        addr_n[0] = {addr_int[0][31:2], 2'b10};
      end else begin
        // head word used up, shift everything down by one
        addr_n  = {32'b0, addr_int[FIFO_DEPTH-1:1]};
        rdata_n = {32'b0, rdata_int[FIFO_DEPTH-1:1]};
        err_n   = {1'b0, err_int[FIFO_DEPTH-1:1]};
        valid_n = {1'b0, valid_int[FIFO_DEPTH-1:1]};
        // unaligned 32 bit ends halfway into the next word
        if (head_addr[1] && !un_compressed) begin
          addr_n[0] = {word_next, 2'b10};
        end else begin
          addr_n[0] = {word_next, 2'b00};
        end
      end
    end
  end

  // stored words
  always_comb begin
    occupancy_o = '0;
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      occupancy_o = occupancy_o + OCC_W'(valid_q[i]);
    end
  end

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (clear_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_n;
    end
  end

  // payload follows valid_q
  always_ff @(posedge clk_i) begin
    addr_q  <= addr_n;
    rdata_q <= rdata_n;
    err_q   <= err_n;
  end

endmodule

`default_nettype wire

/* verilog/fetch_requester.sv */
//////////////////////////////
// bus side of the prefetcher
// raises word requests while the fifo has room, tracks outstanding responses
// and drops the ones that belong to the path before a branch
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fetch_requester #(
  parameter int FIFO_DEPTH      = fetch_pkg::FIFO_DEPTH_DEFAULT,
  parameter int MAX_OUTSTANDING = fetch_pkg::MAX_OUTSTANDING_DEFAULT
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [31:0]                     boot_addr_i,
  input  logic [31:0]                     branch_addr_i,
  input  logic                            branch_i,
  output fetch_pkg::bus_req_t             bus_req_o,
  input  fetch_pkg::bus_rsp_t             bus_rsp_i,
  input  logic [$clog2(FIFO_DEPTH+1)-1:0] occupancy_i,
  output fetch_pkg::fetch_rsp_t           rsp_o,
  output logic                            rsp_valid_o,
  output logic                            clear_o
);

  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

  fetch_pkg::req_state_e state_q, state_d;

  logic [CNT_W-1:0] outstanding_q, outstanding_d;
  logic [CNT_W-1:0] discard_q, discard_d;
  // ungranted request left over from the old path
  logic             stale_q, stale_d;
  logic [31:0]      stale_addr_q;
  logic [31:0]      req_addr_q;
  logic [31:0]      rsp_addr_q;
  logic             can_issue;
  logic             grant;
  logic             grant_new;
  logic             drop;

  // space rule, words stored plus words on the way stay below depth
  assign can_issue = (state_q != fetch_pkg::REQ_IDLE) &&
                     (int'(occupancy_i) + int'(outstanding_q) < FIFO_DEPTH) &&
                     (int'(outstanding_q) < MAX_OUTSTANDING);

  // a stale request keeps its address until granted
  assign bus_req_o.req  = stale_q | can_issue;
  assign bus_req_o.addr = stale_q ? stale_addr_q : req_addr_q;

  assign grant     = bus_req_o.req & bus_rsp_i.gnt;
  assign grant_new = grant & ~stale_q;

  assign outstanding_d = outstanding_q + CNT_W'(grant) - CNT_W'(bus_rsp_i.rvalid);

  // old path responses never reach the fifo
  assign drop = branch_i | ((state_q == fetch_pkg::REQ_FLUSH) && (discard_q != '0));

  assign rsp_valid_o = bus_rsp_i.rvalid & ~drop;
  assign rsp_o.addr  = rsp_addr_q;
  assign rsp_o.rdata = bus_rsp_i.rdata;
  assign rsp_o.err   = bus_rsp_i.err;
  assign clear_o     = branch_i;

  // discard bookkeeping
  always_comb begin
    stale_d   = stale_q & ~grant;
    discard_d = discard_q;
    if (branch_i) begin
      // everything in flight now belongs to the old path
      stale_d   = bus_req_o.req & ~bus_rsp_i.gnt;
      discard_d = outstanding_d;
    end else begin
      if (drop && bus_rsp_i.rvalid) begin
        discard_d = discard_d - CNT_W'(1);
      end
      if (grant && stale_q) begin
        discard_d = discard_d + CNT_W'(1);
      end
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      fetch_pkg::REQ_IDLE: begin
        state_d = fetch_pkg::REQ_FETCH;
      end
      fetch_pkg::REQ_FETCH: begin
        if (branch_i && (discard_d != '0 || stale_d)) begin
          state_d = fetch_pkg::REQ_FLUSH;
        end
      end
      fetch_pkg::REQ_FLUSH: begin
        if (discard_d == '0 && !stale_d) begin
          state_d = fetch_pkg::REQ_FETCH;
        end
      end
      default: begin
        state_d = fetch_pkg::REQ_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= fetch_pkg::REQ_IDLE;
      outstanding_q <= '0;
      discard_q     <= '0;
      stale_q       <= 1'b0;
      req_addr_q    <= '0;
      rsp_addr_q    <= '0;
    end else begin
      state_q       <= state_d;
      outstanding_q <= outstanding_d;
      discard_q     <= discard_d;
      stale_q       <= stale_d;
      if (branch_i) begin
        // requests go by word, responses keep the halfword offset
        req_addr_q <= {branch_addr_i[31:2], 2'b00};
        rsp_addr_q <= {branch_addr_i[31:1], 1'b0};
      end else if (state_q == fetch_pkg::REQ_IDLE) begin
        req_addr_q <= {boot_addr_i[31:2], 2'b00};
        rsp_addr_q <= {boot_addr_i[31:1], 1'b0};
      end else begin
        if (grant_new) begin
          req_addr_q <= req_addr_q + 32'd4;
        end
        if (rsp_valid_o) begin
          rsp_addr_q <= {rsp_addr_q[31:2] + 30'h1, 2'b00};
        end
      end
    end
  end

  // address of the request that a branch overtook
  always_ff @(posedge clk_i) begin
    if (branch_i) begin
      stale_addr_q <= bus_req_o.addr;
    end
  end

endmodule

`default_nettype wire

/* verilog/prefetch_top.sv */
//////////////////////////////
// instruction prefetch subsystem
// bus requester feeding the realigning fetch FIFO
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module prefetch_top #(
  parameter int FIFO_DEPTH      = fetch_pkg::FIFO_DEPTH_DEFAULT,
  parameter int MAX_OUTSTANDING = fetch_pkg::MAX_OUTSTANDING_DEFAULT
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [31:0]             boot_addr_i,
  input  logic                    branch_i,
  input  logic [31:0]             branch_addr_i,
  output fetch_pkg::bus_req_t     bus_req_o,
  input  fetch_pkg::bus_rsp_t     bus_rsp_i,
  output fetch_pkg::fetch_instr_t instr_o,
  output logic                    instr_valid_o,
  input  logic                    instr_ready_i
);

  // requester to fifo
  fetch_pkg::fetch_rsp_t           rsp;
  logic                            rsp_valid;
  logic                            clear;
  logic [$clog2(FIFO_DEPTH+1)-1:0] occupancy;

  fetch_requester #(
    .FIFO_DEPTH      (FIFO_DEPTH),
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_requester (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .boot_addr_i   (boot_addr_i),
    .branch_addr_i (branch_addr_i),
    .branch_i      (branch_i),
    .bus_req_o     (bus_req_o),
    .bus_rsp_i     (bus_rsp_i),
    .occupancy_i   (occupancy),
    .rsp_o         (rsp),
    .rsp_valid_o   (rsp_valid),
    .clear_o       (clear)
  );

  fetch_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear),
    .rsp_i         (rsp),
    .rsp_valid_i   (rsp_valid),
    .occupancy_o   (occupancy),
    .instr_o       (instr_o),
    .instr_valid_o (instr_valid_o),
    .instr_ready_i (instr_ready_i)
  );

endmodule

`default_nettype wire

/* bench/prefetch_assertions.sv */
//////////////////////////////
// concurrent checks for the prefetcher, bound into the FIFO and the requester
// ports a target does not own are tied off in its bind
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module prefetch_assertions #(
  parameter int FIFO_DEPTH      = fetch_pkg::FIFO_DEPTH_DEFAULT,
  parameter int MAX_OUTSTANDING = fetch_pkg::MAX_OUTSTANDING_DEFAULT
) (
  input logic        clk_i,
  input logic        rst_ni,
  input logic [31:0] occupancy_i,
  input logic        rsp_valid_i,
  input logic        req_i,
  input logic [31:0] addr_i,
  input logic        gnt_i,
  input logic [31:0] outstanding_i
);

  // a word arriving at a full fifo would be lost
  a_no_rsp_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_i |-> (occupancy_i < 32'(FIFO_DEPTH)))
    else $error("response arrived while the fifo held %0d words", occupancy_i);

  // request stays up with the same address until granted
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i && !gnt_i) |=> (req_i && $stable(addr_i)))
    else $error("bus request dropped or address moved before grant");

  // granted but unanswered requests
  a_outstanding_limit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    outstanding_i <= 32'(MAX_OUTSTANDING))
    else $error("%0d requests outstanding", outstanding_i);

endmodule

//////////////////////////////
// attach points
//////////////////////////////

bind fetch_fifo prefetch_assertions #(
  .FIFO_DEPTH (FIFO_DEPTH)
) u_fifo_checks (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .occupancy_i   (32'(occupancy_o)),
  .rsp_valid_i   (rsp_valid_i),
  .req_i         (1'b0),
  .addr_i        (32'h0),
  .gnt_i         (1'b0),
  .outstanding_i (32'h0)
);

bind fetch_requester prefetch_assertions #(
  .FIFO_DEPTH      (FIFO_DEPTH),
  .MAX_OUTSTANDING (MAX_OUTSTANDING)
) u_bus_checks (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .occupancy_i   (32'(occupancy_i)),
  .rsp_valid_i   (1'b0),
  .req_i         (bus_req_o.req),
  .addr_i        (bus_req_o.addr),
  .gnt_i         (bus_rsp_i.gnt),
  .outstanding_i (32'(outstanding_q))
);

`default_nettype wire

/* bench/prefetch_tb.sv */
//////////////////////////////
// testbench for the prefetch subsystem
// memory image, branches and the expected instruction stream come from the data file
// models an in-order request/grant bus with random delays
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module prefetch_tb;

  localparam int FIFO_DEPTH      = fetch_pkg::FIFO_DEPTH_DEFAULT;
  localparam int MAX_OUTSTANDING = fetch_pkg::MAX_OUTSTANDING_DEFAULT;
  localparam int MAX_REC         = 64;
  localparam int MEM_WORDS       = 1024;

  logic                    clk_i         = 1'b0;
  logic                    rst_ni        = 1'b1;
  logic [31:0]             boot_addr_i   = 32'h0;
  logic                    branch_i      = 1'b0;
  logic [31:0]             branch_addr_i = 32'h0;
  fetch_pkg::bus_req_t     bus_req_o;
  fetch_pkg::bus_rsp_t     bus_rsp_i     = '0;
  fetch_pkg::fetch_instr_t instr_o;
  logic                    instr_valid_o;
  logic                    instr_ready_i = 1'b0;

  // five columns per record: kind, three fields, flags
  logic [31:0] tdata [0:5*MAX_REC-1];
  logic [31:0] mem_data [0:MEM_WORDS-1];
  logic        mem_err [0:MEM_WORDS-1];
  logic        mem_set [0:MEM_WORDS-1];

  fetch_pkg::fetch_instr_t exp_q [0:MAX_REC-1];
  int          exp_id [0:MAX_REC-1];
  logic        exp_rnd [0:MAX_REC-1];
  int          br_after [0:MAX_REC-1];
  logic [31:0] br_target [0:MAX_REC-1];
  int          n_exp, n_br, exp_idx;
  logic [31:0] boot_addr;

  // bus model state, responses leave in grant order
  logic [31:0] pend_addr [$];
  int          pend_due [$];
  int          last_due, gnt_wait, gnt_delay;
  logic [31:0] lcg_state = 32'hdd2b8370;

  int   cyc, limit, checks, errors, test_checks, test_errs;
  logic finished  = 1'b0;
  logic timed_out = 1'b0;

  prefetch_top #(
    .FIFO_DEPTH      (FIFO_DEPTH),
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) dut0 (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .boot_addr_i   (boot_addr_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .bus_req_o     (bus_req_o),
    .bus_rsp_i     (bus_rsp_i),
    .instr_o       (instr_o),
    .instr_valid_o (instr_valid_o),
    .instr_ready_i (instr_ready_i)
  );

  initial begin
    forever #50 clk_i = ~clk_i;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  // lcg, values 0 .. n-1
  function automatic int next_random(input int n);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return int'(lcg_state[30:16]) % n;
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1: return "aligned32";
      2: return "compressed";
      3: return "unaligned32";
      4: return "branch";
      5: return "error";
      6: return "backpressure";
      default: return "unknown";
    endcase
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    if (addr[31:12] == 20'h0 && mem_set[addr[11:2]]) begin
      return mem_data[addr[11:2]];
    end
    // unlisted words, pattern follows the whole address
    return (addr ^ 32'h5ad13c00) | 32'h3;
  endfunction

  function automatic logic mem_fault(input logic [31:0] addr);
    if (addr[31:12] == 20'h0 && mem_set[addr[11:2]]) begin
      return mem_err[addr[11:2]];
    end
    return 1'b0;
  endfunction

  task automatic load_testdata();
    logic [31:0] kind;
    for (int i = 0; i < 5*MAX_REC; i++) begin
      tdata[i] = 32'h0;
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_set[i] = 1'b0;
      mem_err[i] = 1'b0;
    end
    $readmemh("bench/prefetch_testdata.txt", tdata);
    for (int r = 0; r < MAX_REC; r++) begin
      kind = tdata[5*r];
      if (kind == 32'd1) begin
        mem_data[tdata[5*r+1][11:2]] = tdata[5*r+2];
        mem_err[tdata[5*r+1][11:2]]  = tdata[5*r+4][0];
        mem_set[tdata[5*r+1][11:2]]  = 1'b1;
      end else if (kind == 32'd2) begin
        br_after[n_br]  = int'(tdata[5*r+1]);
        br_target[n_br] = tdata[5*r+2];
        n_br++;
      end else if (kind == 32'd3) begin
        exp_id[n_exp]      = int'(tdata[5*r+1]);
        exp_q[n_exp].addr  = tdata[5*r+2];
        exp_q[n_exp].instr = tdata[5*r+3];
        exp_q[n_exp].err   = tdata[5*r+4][0];
        exp_rnd[n_exp]     = tdata[5*r+4][4];
        n_exp++;
      end else if (kind == 32'd4) begin
        boot_addr = tdata[5*r+1];
      end
    end
  endtask

  //////////////////////////////
  // checks
  //////////////////////////////

  // 16 bit expected values compare the low half only
  task automatic check_instr(input string test, input fetch_pkg::fetch_instr_t exp,
                             input fetch_pkg::fetch_instr_t act);
    logic compressed;
    logic ok;
    compressed = exp.instr[1:0] != 2'b11;
    ok = (act.addr === exp.addr) && (act.err === exp.err);
    if (compressed) begin
      ok = ok && (act.instr[15:0] === exp.instr[15:0]);
    end else begin
      ok = ok && (act.instr === exp.instr);
    end
    checks++;
    test_checks++;
    if (!ok) begin
      errors++;
      test_errs++;
      $display("Fail %s expected addr %h instr %h err %b actual addr %h instr %h err %b",
               test, exp.addr, exp.instr, exp.err, act.addr,
               compressed ? {16'h0, act.instr[15:0]} : act.instr, act.err);
    end
  endtask

  task automatic check_bus(input string test, input fetch_pkg::bus_req_t exp,
                           input fetch_pkg::bus_req_t act);
    checks++;
    if (act.req !== exp.req) begin
      errors++;
      $display("Fail %s expected req %b actual req %b", test, exp.req, act.req);
    end
  endtask

  //////////////////////////////
  // bus and output side
  //////////////////////////////

  // sees the cycle that just ended, drives the next one
  task automatic model_bus();
    int d;
    int due;
    fetch_pkg::bus_rsp_t nxt;
    if (bus_req_o.req && bus_rsp_i.gnt) begin
      d   = next_random(3);
      due = cyc + d;
      // one rvalid per cycle, in order
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      pend_addr.push_back(bus_req_o.addr);
      pend_due.push_back(due);
      gnt_delay = next_random(3);
      gnt_wait  = 0;
    end else if (bus_req_o.req) begin
      gnt_wait++;
    end
    nxt     = '0;
    nxt.gnt = gnt_wait >= gnt_delay;
    if (pend_due.size() > 0 && pend_due[0] <= cyc) begin
      nxt.rvalid = 1'b1;
      nxt.rdata  = mem_word(pend_addr[0]);
      nxt.err    = mem_fault(pend_addr[0]);
      void'(pend_addr.pop_front());
      void'(pend_due.pop_front());
    end
    bus_rsp_i <= nxt;
  endtask

  task automatic watch_output();
    fetch_pkg::fetch_instr_t got;
    branch_i <= 1'b0;
    if (instr_valid_o && instr_ready_i && exp_idx < n_exp) begin
      got = instr_o;
      check_instr(test_name(exp_id[exp_idx]), exp_q[exp_idx], got);
      // branch pulses in the cycle after this transfer
      for (int b = 0; b < n_br; b++) begin
        if (br_after[b] == exp_idx) begin
          branch_i      <= 1'b1;
          branch_addr_i <= br_target[b];
        end
      end
      if (exp_idx == n_exp - 1 || exp_id[exp_idx+1] != exp_id[exp_idx]) begin
        $display("test %s: %0d instructions, %0d errors",
                 test_name(exp_id[exp_idx]), test_checks, test_errs);
        test_checks = 0;
        test_errs   = 0;
      end
      exp_idx++;
    end
    if (exp_idx >= n_exp) begin
      finished = 1'b1;
    end else if (exp_rnd[exp_idx]) begin
      instr_ready_i <= next_random(2) == 1;
    end else begin
      instr_ready_i <= 1'b1;
    end
  endtask

  always @(posedge clk_i) begin
    if (rst_ni && !finished) begin
      cyc = cyc + 1;
      model_bus();
      watch_output();
      if (!finished && cyc >= limit) begin
        timed_out = 1'b1;
        finished  = 1'b1;
        $display("test %s: no instruction arrived before timeout, %0d of %0d received",
                 test_name(exp_id[exp_idx]), exp_idx, n_exp);
      end
    end
  end

  //////////////////////////////
  // reset and end of run
  //////////////////////////////

  initial begin
    fetch_pkg::bus_req_t idle_req;
    idle_req = '0;
    rst_ni <= 1'b0;
    load_testdata();
    limit = n_exp * 12 + 200;
    for (int c = 0; c < 4; c++) begin
      @(posedge clk_i);
      check_bus("reset", idle_req, bus_req_o);
      if (c == 0) begin
        boot_addr_i <= boot_addr;
      end
    end
    rst_ni <= 1'b1;
    $display("test reset: 4 cycles, %0d errors", errors);
    wait (finished);
    $display("closing: %0d checks, %0d errors, %0d of %0d instructions",
             checks, errors, exp_idx, n_exp);
    if (errors == 0 && !timed_out) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/prefetch_testdata.txt */
// kind 1 memory: address data 0 err / kind 2 branch: after-index target 0 0 / kind 4 boot
// kind 3 expected: test-id address instr flags (flags bit 4 random ready, bit 0 err)
4 00000100 00000000 00000000 00
1 00000100 00000013 00000000 00
1 00000104 00100093 00000000 00
1 00000108 05134585 00000000 00
1 0000010C 450500A0 00000000 00
1 00000200 47050001 00000000 00
1 00000204 00C00613 00000000 00
1 00000300 07934785 00000000 00
1 00000304 480100F0 00000000 01
1 00000308 00100093 00000000 00
1 0000030C 49054885 00000000 00
1 00000310 01300993 00000000 00
1 00000314 00200113 00000000 00
2 00000004 00000202 00000000 00
2 00000006 00000300 00000000 00
3 00000001 00000100 00000013 00
3 00000001 00000104 00100093 00
3 00000002 00000108 00004585 00
3 00000003 0000010A 00A00513 00
3 00000003 0000010E 00004505 00
3 00000004 00000202 00004705 00
3 00000004 00000204 00C00613 00
3 00000005 00000300 00004785 00
3 00000005 00000302 00F00793 01
3 00000005 00000306 00004801 01
3 00000006 00000308 00100093 10
3 00000006 0000030C 00004885 10
3 00000006 0000030E 00004905 10
3 00000006 00000310 01300993 10
3 00000006 00000314 00200113 10

/* list.f */
verilog/fetch_pkg.sv
verilog/fetch_fifo.sv
verilog/fetch_requester.sv
verilog/prefetch_top.sv
bench/prefetch_assertions.sv
bench/prefetch_tb.sv

/* run.sh */
#!/bin/sh
# build the prefetch testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module prefetch_tb -o prefetch_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/prefetch_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1
